/* vlog.f */
hw/lsu_dccm_pkg.sv
hw/dccm_req_ctl.sv
hw/dccm_load_pipe.sv
hw/dccm_wr_arb.sv
hw/lsu_dccm_ctl.sv
sim/lsu_dccm_ctl_assert.sv
sim/tb_lsu_dccm_ctl.sv

/* Bender.yml */
package:
  name: lsu_dccm_ctl

sources:
  - files:
      - hw/lsu_dccm_pkg.sv
      - hw/dccm_req_ctl.sv
      - hw/dccm_load_pipe.sv
      - hw/dccm_wr_arb.sv
      - hw/lsu_dccm_ctl.sv
  - target: simulation
    files:
      - sim/lsu_dccm_ctl_assert.sv
      - sim/tb_lsu_dccm_ctl.sv

/* sim/tb_lsu_dccm_ctl.sv */
// Testbench for the DCCM control slice. Models both SRAM banks, runs random loads
// with forwarding and ECC status, then mixed traffic against a draining store buffer.
`timescale 1ns/100ps
`default_nettype none

module tb_lsu_dccm_ctl import lsu_dccm_pkg::*; ();

   localparam int AW     = 16;
   localparam int NWORDS = 1 << (AW - 2);

   // one access plus what it needs later in M and R
   typedef struct packed {
      logic                 v;
      lsu_pkt_t             pkt;
      logic [AW-1:0]        addr;
      logic                 hit;     // address in dccm
      stbuf_fwd_t           fwd;
      logic [DMA_TAG_W-1:0] tag;
      logic                 commit;
      ecc_r_t               ecc;
      logic [DCCM_DW-1:0]   lo_w;    // array words seen in D
      logic [DCCM_DW-1:0]   hi_w;
   } acc_t;

   logic                 clk;
   logic                 arst_n;
   lsu_pkt_t             lsu_pkt_d;
   logic [AW-1:0]        lsu_addr_d;
   logic                 addr_in_dccm_d;
   dma_wr_t              dma_wr;
   logic [DMA_TAG_W-1:0] dma_tag_m;
   stbuf_fwd_t           stbuf_fwd_m;
   logic                 lsu_commit_r;
   ecc_r_t               ecc_r;
   logic                 stbuf_reqvld;
   logic [AW-1:0]        stbuf_addr;
   dccm_word_t           stbuf_wr, rd_data_lo, rd_data_hi, wr_data_lo, wr_data_hi;
   logic                 dccm_rden, dccm_wren, stbuf_commit, ld_single_ecc_error_r;
   logic [AW-1:0]        rd_addr_lo, rd_addr_hi, wr_addr_lo, wr_addr_hi;
   logic [DCCM_DW-1:0]   ld_data_r, ld_data_corr_r;
   dma_rsp_t             dma_rsp;

   dccm_word_t mem_lo [NWORDS];
   dccm_word_t mem_hi [NWORDS];
   acc_t       pipe [3];   // D, M, R
   acc_t       wb_ent;     // load whose fix owns the port this cycle
   logic       wb_now;
   int         val_errs;
   int         oth_errs;

   lsu_dccm_ctl #(.DCCM_AW(AW)) u_lsu_dccm_ctl (.*);

   initial clk = 1'b0;
   always #10 clk = ~clk;

   always @(posedge clk) begin  // sram model with read data one cycle after rden
      if (dccm_rden) begin
         rd_data_lo <= mem_lo[rd_addr_lo[AW-1:2]];
         rd_data_hi <= mem_hi[rd_addr_hi[AW-1:2]];
      end
      if (dccm_wren) begin
         mem_lo[wr_addr_lo[AW-1:2]] <= wr_data_lo;
         mem_hi[wr_addr_hi[AW-1:2]] <= wr_data_hi;
      end
   end

   function automatic dccm_word_t fill(input int i);
      dccm_word_t w;
      w.data = 32'(i) * 32'h9e37_79b1 + 32'h1357_2468;
      w.ecc  = DCCM_EW'(i ^ (i >> 7));
      return w;
   endfunction

   function automatic logic [AW-1:0] end_of(input lsu_pkt_t p, input logic [AW-1:0] a);
      int size;
      size = p.dword ? 8 : p.word ? 4 : p.half ? 2 : 1;
      return a + AW'(size - 1);
   endfunction

   function automatic logic is_dual(input lsu_pkt_t p, input logic [AW-1:0] a);
      return (end_of(p, a) >> 2) != (a >> 2);
   endfunction

   function automatic logic rden_ref(input lsu_pkt_t p, input logic [AW-1:0] a, input logic hit);
      logic full_st;
      full_st = (p.word | p.dword) && (a[1:0] == 2'b00);
      return p.valid & hit & (p.load | (p.store & ~full_st));
   endfunction

   // busy is a dma write or a correction write in the same cycle
   function automatic logic commit_ref(input lsu_pkt_t p, input logic [AW-1:0] a,
                                       input logic hit, input logic busy, input logic [AW-1:0] sa);
      logic [AW-1:0] e;
      e = end_of(p, a);
      if (!rden_ref(p, a, hit))
         return !busy;
      return (sa[4:2] != a[4:2]) && (sa[4:2] != e[4:2]);
   endfunction

   // byte k of the result is byte ofs+k of {hi,lo} unless forwarded
   function automatic logic [DCCM_DW-1:0] load_ref(input logic [DCCM_DW-1:0] lo,
         input logic [DCCM_DW-1:0] hi, input stbuf_fwd_t fwd, input logic hit,
         input logic [1:0] ofs);
      logic [2*DCCM_DW-1:0] mem;
      logic [DCCM_DW-1:0]   res;
      int                   idx;
      mem = {hi, lo};
      res = '0;
      for (int k = 0; k < 4; k++) begin
         idx = int'(ofs) + k;
         if (fwd.byteen[idx])
            res[8*k +: 8] = fwd.data.bytes[idx];
         else if (hit)
            res[8*k +: 8] = mem[8*idx +: 8];
      end
      return res;
   endfunction

   function automatic logic [DCCM_DW-1:0] size_mask(input lsu_pkt_t p);
      return (p.dword | p.word) ? 32'hffff_ffff : p.half ? 32'h0000_ffff : 32'h0000_00ff;
   endfunction

   function automatic dma_rsp_t dma_ref(input acc_t e);
      dma_rsp_t r;
      r.rvalid        = 1'b1;
      r.ecc_error     = e.ecc.double_err;
      r.rtag          = e.tag;
      r.rdata.bank.lo = e.hit ? e.ecc.sec_lo : '0;
      r.rdata.bank.hi = !is_dual(e.pkt, e.addr) ? r.rdata.bank.lo : e.hit ? e.ecc.sec_hi : '0;
      return r;
   endfunction

   function automatic dccm_word_t wr_ref(input dma_wr_t d, input dccm_word_t sw, input logic hi);
      if (!d.wen)
         return sw;
      return hi ? '{ecc: d.ecc_hi, data: d.wdata_hi} : '{ecc: d.ecc_lo, data: d.wdata_lo};
   endfunction

   task automatic check_word(input string name, input logic [DCCM_DW-1:0] got,
                             input logic [DCCM_DW-1:0] exp);
      if (got !== exp) begin
         val_errs++;
         $display("** Error %s: got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic check_dccm_word(input string name, input dccm_word_t got, input dccm_word_t exp);
      if (got !== exp) begin
         val_errs++;
         $display("** Error %s: got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic check_dma_rsp(input string name, input dma_rsp_t got, input dma_rsp_t exp);
      if (got !== exp) begin
         val_errs++;
         $display("** Error %s: got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   // compare at the rising edge, then advance the expected pipeline
   always @(posedge clk) begin
      acc_t          r;
      logic          exp_cm;
      logic          exp_rd;
      logic          single;
      logic [AW-1:0] wb_hi_addr;
      dccm_word_t    fix_lo;
      dccm_word_t    fix_hi;
      if (arst_n) begin
         r      = pipe[2];
         exp_rd = rden_ref(lsu_pkt_d, lsu_addr_d, addr_in_dccm_d);
         check_word("dccm_rden", dccm_rden, exp_rd);
         if (exp_rd) begin
            check_word("rd_addr_lo", rd_addr_lo, lsu_addr_d);
            check_word("rd_addr_hi", rd_addr_hi, end_of(lsu_pkt_d, lsu_addr_d));
         end
         exp_cm = stbuf_reqvld & commit_ref(lsu_pkt_d, lsu_addr_d, addr_in_dccm_d,
                                            dma_wr.wen | wb_now, stbuf_addr);
         check_word("stbuf_commit", stbuf_commit, exp_cm);
         check_word("dccm_wren", dccm_wren, wb_now | dma_wr.wen | exp_cm);
         if (wb_now) begin
            wb_hi_addr = end_of(wb_ent.pkt, wb_ent.addr);
            fix_lo     = '{ecc: wb_ent.ecc.sec_ecc_lo, data: wb_ent.ecc.sec_lo};
            fix_hi     = '{ecc: wb_ent.ecc.sec_ecc_hi, data: wb_ent.ecc.sec_hi};
            // a clean bank repeats the fix of the failing one
            check_word("wr_addr_lo", wr_addr_lo,
                       wb_ent.ecc.single_lo ? wb_ent.addr : wb_hi_addr);
            check_word("wr_addr_hi", wr_addr_hi,
                       wb_ent.ecc.single_hi ? wb_hi_addr : wb_ent.addr);
            check_dccm_word("wr_data_lo", wr_data_lo,
                            wb_ent.ecc.single_lo ? fix_lo : fix_hi);
            check_dccm_word("wr_data_hi", wr_data_hi,
                            wb_ent.ecc.single_hi ? fix_hi : fix_lo);
         end else if (dma_wr.wen | exp_cm) begin
            check_word("wr_addr_lo", wr_addr_lo, dma_wr.wen ? lsu_addr_d : stbuf_addr);
            check_word("wr_addr_hi", wr_addr_hi,
                       dma_wr.wen ? end_of(lsu_pkt_d, lsu_addr_d) : stbuf_addr);
            check_dccm_word("wr_data_lo", wr_data_lo, wr_ref(dma_wr, stbuf_wr, 1'b0));
            check_dccm_word("wr_data_hi", wr_data_hi, wr_ref(dma_wr, stbuf_wr, 1'b1));
         end
         wb_now = 1'b0;
         if (r.v && r.pkt.load) begin
            check_word("ld_data_r", ld_data_r & size_mask(r.pkt),
                       load_ref(r.lo_w, r.hi_w, r.fwd, r.hit, r.addr[1:0]) & size_mask(r.pkt));
            check_word("ld_data_corr_r", ld_data_corr_r & size_mask(r.pkt),
                       load_ref(r.ecc.sec_lo, r.ecc.sec_hi, r.fwd, r.hit, r.addr[1:0])
                       & size_mask(r.pkt));
            single = (r.ecc.single_lo | r.ecc.single_hi) & ~r.ecc.double_err;
            check_word("ld_single_ecc_error_r", ld_single_ecc_error_r, single);
            wb_now = single & (r.commit | r.pkt.dma);
         end
         if (r.v && r.pkt.load && r.pkt.dma)
            check_dma_rsp("dma_rsp", dma_rsp, dma_ref(r));
         else
            check_word("dma_rsp.rvalid", dma_rsp.rvalid, 1'b0);
         wb_ent  = r;
         pipe[2] = pipe[1];
         pipe[1] = pipe[0];
         pipe[0] = '0;
      end
   end

   // mode 0 loads, mode 1 mixed traffic with store-buffer requests, mode 2 idle
   task automatic drive_cycle(input int mode);
      acc_t          a;
      int            sel;
      logic [AW-1:0] e;
      a   = '0;
      sel = (mode == 2) ? 9 : $urandom_range(0, 9);
      a.v = (sel < 8);
      {a.pkt.by, a.pkt.half, a.pkt.word, a.pkt.dword} = 4'b1000 >> $urandom_range(0, 3);
      a.pkt.valid = a.v;
      a.pkt.load  = a.v && (mode == 0 || sel < 4);
      a.pkt.store = a.v && !a.pkt.load;
      a.pkt.dma   = a.v && ((mode == 0 && sel < 2) || (mode == 1 && sel >= 6));
      a.addr      = AW'($urandom);
      a.hit       = ($urandom_range(0, 7) != 0);
      if (a.pkt.dword || (a.pkt.store && a.pkt.dma))
         a.addr[1:0] = 2'b00;
      if (a.pkt.store && a.pkt.dma && a.pkt.by | a.pkt.half)
         {a.pkt.by, a.pkt.half, a.pkt.word} = 3'b001;
      if (mode == 0 && a.v) begin
         a.tag    = a.pkt.dma ? DMA_TAG_W'($urandom) : '0;
         a.fwd    = (a.pkt.dma || $urandom_range(0, 1)) ? '0 : {$urandom, $urandom, 8'($urandom)};
         a.commit = ($urandom_range(0, 3) != 0);
         a.ecc    = {$urandom_range(0, 7) == 0, $urandom_range(0, 7) == 0,
                     $urandom_range(0, 15) == 0, $urandom, $urandom, 14'($urandom)};
      end
      e      = end_of(a.pkt, a.addr);
      a.lo_w = mem_lo[a.addr[AW-1:2]].data;
      a.hi_w = mem_hi[e[AW-1:2]].data;
      lsu_pkt_d      = a.pkt;
      lsu_addr_d     = a.addr;
      addr_in_dccm_d = a.hit;
      dma_wr         = {a.pkt.store & a.pkt.dma, $urandom, $urandom, 14'($urandom)};
      stbuf_reqvld   = (mode == 1);
      stbuf_addr     = {AW'($urandom)} & ~AW'(3);
      stbuf_wr       = {7'($urandom), $urandom};
      stbuf_fwd_m    = pipe[1].fwd;
      dma_tag_m      = pipe[1].tag;
      lsu_commit_r   = pipe[2].commit;
      ecc_r          = pipe[2].ecc;
      pipe[0]        = a;
   endtask

   initial begin
      int drain;
      void'($urandom(45465));
      val_errs = 0;
      oth_errs = 0;
      wb_now   = 1'b0;
      wb_ent   = '0;
      foreach (pipe[i]) pipe[i] = '0;
      for (int i = 0; i < NWORDS; i++) begin
         mem_lo[i] = fill(i);
         mem_hi[i] = fill(i);
      end
      arst_n     = 1'b0;
      rd_data_lo = '0;
      rd_data_hi = '0;
      drive_cycle(2);
      pipe[0] = '0;
      repeat (16) @(negedge clk);
      arst_n = 1'b1;
      for (int n = 0; n < 800; n++) begin
         @(negedge clk);
         drive_cycle(n < 400 ? 0 : 1);
      end
      for (drain = 0; drain < 10 && (pipe[0].v || pipe[1].v || pipe[2].v || wb_now); drain++) begin
         @(negedge clk);
         drive_cycle(2);
      end
      if (drain == 10) begin
         oth_errs++;
         $display("pipeline still busy ten cycles after the last access");
      end
      $display("value errors: %0d, other errors: %0d", val_errs, oth_errs);
      if (val_errs == 0 && oth_errs == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule

`default_nettype wire

/* sim/lsu_dccm_ctl_assert.sv */
// Write port checks for the DCCM control slice.
// Bound to every instance of the top level by the bind below.
`timescale 1ns/100ps
`default_nettype none

module lsu_dccm_ctl_assert import lsu_dccm_pkg::*; #(
   parameter int DCCM_AW = 16
) (
   input logic               clk,
   input logic               arst_n,
   input logic               dccm_wren,
   input logic               stbuf_commit,
   input dma_wr_t            dma_wr,
   input logic               ecc_wb_pend,
   input logic [DCCM_AW-1:0] stbuf_addr,
   input dccm_word_t         stbuf_wr,
   input logic [DCCM_AW-1:0] wr_addr_lo,
   input dccm_word_t         wr_data_lo
);

   // a granted entry reaches the array unless a correction write owns the port
   commit_writes: assert property (@(posedge clk) disable iff (!arst_n)
      stbuf_commit |-> dccm_wren &&
         (ecc_wb_pend || (wr_addr_lo == stbuf_addr && wr_data_lo == stbuf_wr)))
      else $error("stbuf_commit without its entry on the write port");

   no_write_in_reset: assert property (@(posedge clk) !arst_n |-> !dccm_wren)
      else $error("dccm_wren high during reset");

   dma_owns_port: assert property (@(posedge clk) disable iff (!arst_n)
      dma_wr.wen |-> !stbuf_commit)
      else $error("stbuf_commit in the same cycle as a dma write");

endmodule

bind lsu_dccm_ctl lsu_dccm_ctl_assert #(.DCCM_AW(DCCM_AW)) u_assert (
   .clk, .arst_n, .dccm_wren, .stbuf_commit, .dma_wr,
   .ecc_wb_pend, .stbuf_addr, .stbuf_wr, .wr_addr_lo, .wr_data_lo
);

`default_nettype wire

/* hw/lsu_dccm_ctl.sv */
// Top of the DCCM control slice. Connects decode request logic, the load
// pipeline and the write port arbiter, and sets the DCCM address width.
`timescale 1ns/100ps
`default_nettype none

module lsu_dccm_ctl import lsu_dccm_pkg::*; #(
   parameter int DCCM_AW = 16
) (
   input  logic                 clk,
   input  logic                 arst_n,
   input  lsu_pkt_t             lsu_pkt_d,
   input  logic [DCCM_AW-1:0]   lsu_addr_d,
   input  logic                 addr_in_dccm_d,
   input  dma_wr_t              dma_wr,
   input  logic [DMA_TAG_W-1:0] dma_tag_m,
   input  stbuf_fwd_t           stbuf_fwd_m,
   input  logic                 lsu_commit_r,
   input  ecc_r_t               ecc_r,
   input  logic                 stbuf_reqvld,
   input  logic [DCCM_AW-1:0]   stbuf_addr,
   input  dccm_word_t           stbuf_wr,
   input  dccm_word_t           rd_data_lo,
   input  dccm_word_t           rd_data_hi,

   output logic                 dccm_rden,
   output logic [DCCM_AW-1:0]   rd_addr_lo,
   output logic [DCCM_AW-1:0]   rd_addr_hi,
   output logic                 dccm_wren,
   output logic [DCCM_AW-1:0]   wr_addr_lo,
   output logic [DCCM_AW-1:0]   wr_addr_hi,
   output dccm_word_t           wr_data_lo,
   output dccm_word_t           wr_data_hi,
   output logic                 stbuf_commit,
   output logic [DCCM_DW-1:0]   ld_data_r,
   output logic [DCCM_DW-1:0]   ld_data_corr_r,
   output dma_rsp_t             dma_rsp,
   output logic                 ld_single_ecc_error_r
);

   logic               rden_d;
   logic [DCCM_AW-1:0] end_addr_d;
   logic               dual_d;
   logic               ecc_wb_pend;
   lsu_pkt_t           lsu_pkt_r;
   logic [DCCM_AW-1:0] lsu_addr_r;
   logic [DCCM_AW-1:0] end_addr_r;

   dccm_req_ctl #(.DCCM_AW(DCCM_AW)) u_req (
      .clk, .arst_n, .lsu_pkt_d, .lsu_addr_d, .addr_in_dccm_d,
      .dma_wen(dma_wr.wen),
      .stbuf_reqvld, .stbuf_addr, .ecc_wb_pend,
      .rden_d, .end_addr_d, .dual_d, .stbuf_commit,
      .dccm_rden, .rd_addr_lo, .rd_addr_hi
   );

   dccm_load_pipe #(.DCCM_AW(DCCM_AW)) u_load (
      .clk, .arst_n, .lsu_pkt_d, .lsu_addr_d, .end_addr_d, .dual_d, .rden_d,
      .addr_in_dccm_d, .rd_data_lo, .rd_data_hi, .stbuf_fwd_m, .dma_tag_m, .ecc_r,
      .lsu_pkt_r, .lsu_addr_r, .end_addr_r, .ld_data_r, .ld_data_corr_r, .dma_rsp
   );

   dccm_wr_arb #(.DCCM_AW(DCCM_AW)) u_wr (
      .clk, .arst_n, .lsu_pkt_r, .lsu_addr_r, .end_addr_r, .lsu_commit_r, .ecc_r,
      .lsu_addr_d, .end_addr_d, .dma_wr, .stbuf_commit, .stbuf_addr, .stbuf_wr,
      .ecc_wb_pend, .ld_single_ecc_error_r, .dccm_wren,
      .wr_addr_lo, .wr_addr_hi, .wr_data_lo, .wr_data_hi
   );

endmodule

`default_nettype wire

/* hw/dccm_wr_arb.sv */
// ECC correction state and DCCM write port arbitration.
// Priority is correction writeback, then DMA write, then store buffer.
`timescale 1ns/100ps
`default_nettype none

module dccm_wr_arb import lsu_dccm_pkg::*; #(
   parameter int DCCM_AW = 16
) (
   input  logic               clk,
   input  logic               arst_n,
   input  lsu_pkt_t           lsu_pkt_r,
   input  logic [DCCM_AW-1:0] lsu_addr_r,
   input  logic [DCCM_AW-1:0] end_addr_r,
   input  logic               lsu_commit_r,
   input  ecc_r_t             ecc_r,
   input  logic [DCCM_AW-1:0] lsu_addr_d,
   input  logic [DCCM_AW-1:0] end_addr_d,
   input  dma_wr_t            dma_wr,
   input  logic               stbuf_commit,
   input  logic [DCCM_AW-1:0] stbuf_addr,
   input  dccm_word_t         stbuf_wr,

   output logic               ecc_wb_pend,
   output logic               ld_single_ecc_error_r,
   output logic               dccm_wren,
   output logic [DCCM_AW-1:0] wr_addr_lo,
   output logic [DCCM_AW-1:0] wr_addr_hi,
   output dccm_word_t         wr_data_lo,
   output dccm_word_t         wr_data_hi
);

   logic               ld_r;         // load in R
   logic               sec_lo_r;
   logic               sec_hi_r;
   logic               wb_take_r;    // load commits or is dma
   logic               wb_lo_q;
   logic               wb_hi_q;
   logic [DCCM_AW-1:0] sec_addr_lo_q;
   logic [DCCM_AW-1:0] sec_addr_hi_q;
   dccm_word_t         sec_word_lo_q;
   dccm_word_t         sec_word_hi_q;

   assign ld_r     = lsu_pkt_r.valid & lsu_pkt_r.load;
   assign sec_lo_r = ld_r & ecc_r.single_lo;
   assign sec_hi_r = ld_r & ecc_r.single_hi;

   assign ld_single_ecc_error_r = (sec_lo_r | sec_hi_r) & ~ecc_r.double_err;
   assign wb_take_r             = (lsu_commit_r | lsu_pkt_r.dma) & ~ecc_r.double_err;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wb_lo_q <= 1'b0;
         wb_hi_q <= 1'b0;
      end else begin
         wb_lo_q <= sec_lo_r & wb_take_r;
         wb_hi_q <= sec_hi_r & wb_take_r;
      end
   end

   // corrected words wait one cycle for the port
   always_ff @(posedge clk) begin
      if (ld_single_ecc_error_r) begin
         sec_addr_lo_q <= lsu_addr_r;
         sec_addr_hi_q <= end_addr_r;
         sec_word_lo_q <= '{ecc: ecc_r.sec_ecc_lo, data: ecc_r.sec_lo};
         sec_word_hi_q <= '{ecc: ecc_r.sec_ecc_hi, data: ecc_r.sec_hi};
      end
   end

   assign ecc_wb_pend = wb_lo_q | wb_hi_q;
   assign dccm_wren   = ecc_wb_pend | dma_wr.wen | stbuf_commit;

   always_comb begin
      if (ecc_wb_pend) begin  // a clean bank takes the other bank's fix
         wr_addr_lo = wb_lo_q ? sec_addr_lo_q : sec_addr_hi_q;
         wr_addr_hi = wb_hi_q ? sec_addr_hi_q : sec_addr_lo_q;
         wr_data_lo = wb_lo_q ? sec_word_lo_q : sec_word_hi_q;
         wr_data_hi = wb_hi_q ? sec_word_hi_q : sec_word_lo_q;
      end else if (dma_wr.wen) begin
         wr_addr_lo = lsu_addr_d;
         wr_addr_hi = end_addr_d;
         wr_data_lo = '{ecc: dma_wr.ecc_lo, data: dma_wr.wdata_lo};
         wr_data_hi = '{ecc: dma_wr.ecc_hi, data: dma_wr.wdata_hi};
      end else begin
         wr_addr_lo = stbuf_addr;  // stbuf entry is one aligned word
         wr_addr_hi = stbuf_addr;
         wr_data_lo = stbuf_wr;
         wr_data_hi = stbuf_wr;
      end
   end

endmodule

`default_nettype wire

/* hw/dccm_load_pipe.sv */
// Load pipeline from D through M to R. Captures the bank read data, merges
// store-buffer forwarding per byte, right-justifies the result and builds the
// DMA read return.
`timescale 1ns/100ps
`default_nettype none

module dccm_load_pipe import lsu_dccm_pkg::*; #(
   parameter int DCCM_AW = 16
) (
   input  logic                 clk,
   input  logic                 arst_n,
   input  lsu_pkt_t             lsu_pkt_d,
   input  logic [DCCM_AW-1:0]   lsu_addr_d,
   input  logic [DCCM_AW-1:0]   end_addr_d,
   input  logic                 dual_d,
   input  logic                 rden_d,
   input  logic                 addr_in_dccm_d,
   input  dccm_word_t           rd_data_lo,    // sram output, valid in M
   input  dccm_word_t           rd_data_hi,
   input  stbuf_fwd_t           stbuf_fwd_m,
   input  logic [DMA_TAG_W-1:0] dma_tag_m,
   input  ecc_r_t               ecc_r,

   output lsu_pkt_t             lsu_pkt_r,
   output logic [DCCM_AW-1:0]   lsu_addr_r,
   output logic [DCCM_AW-1:0]   end_addr_r,
   output logic [DCCM_DW-1:0]   ld_data_r,
   output logic [DCCM_DW-1:0]   ld_data_corr_r,
   output dma_rsp_t             dma_rsp
);

   lsu_pkt_t              pkt_m;
   logic [DCCM_AW-1:0]    addr_m;
   logic [DCCM_AW-1:0]    end_addr_m;
   logic                  rden_m;
   logic                  dual_m;
   logic                  dual_r;
   logic                  in_dccm_m;
   logic                  in_dccm_r;
   logic [DMA_TAG_W-1:0]  dma_tag_r;
   dword_u                rdata_r;       // bank words as read
   dword_u                fwd_data_r;
   logic [DCCM_BYTES-1:0] fwd_byteen_r;
   dword_u                corr_dw_r;     // corrected bank words
   dword_u                ld_dw_r;       // merged raw dword
   dword_u                ld_dw_corr_r;  // merged corrected dword

   // forwarded byte first, then array byte, zero outside the dccm
   function automatic dword_u merge_bytes(input dword_u mem, input dword_u fwd,
                                          input logic [DCCM_BYTES-1:0] byteen,
                                          input logic hit);
      dword_u res;
      for (int i = 0; i < DCCM_BYTES; i++) begin
         res.bytes[i] = byteen[i] ? fwd.bytes[i] : (mem.bytes[i] & {8{hit}});
      end
      return res;
   endfunction

   function automatic logic [DCCM_DW-1:0] align_word(input dword_u dw, input logic [1:0] ofs);
      return DCCM_DW'(dw >> {ofs, 3'b000});
   endfunction

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pkt_m        <= '0;
         lsu_pkt_r    <= '0;
         rden_m       <= 1'b0;
         dual_m       <= 1'b0;
         dual_r       <= 1'b0;
         in_dccm_m    <= 1'b0;
         in_dccm_r    <= 1'b0;
         fwd_byteen_r <= '0;
      end else begin
         pkt_m        <= lsu_pkt_d;
         lsu_pkt_r    <= pkt_m;
         rden_m       <= rden_d;
         dual_m       <= dual_d;
         dual_r       <= dual_m;
         in_dccm_m    <= addr_in_dccm_d;
         in_dccm_r    <= in_dccm_m;
         fwd_byteen_r <= stbuf_fwd_m.byteen;
      end
   end

   always_ff @(posedge clk) begin
      addr_m     <= lsu_addr_d;
      end_addr_m <= end_addr_d;
      lsu_addr_r <= addr_m;
      end_addr_r <= end_addr_m;
      dma_tag_r  <= dma_tag_m;
      if (rden_m) begin
         rdata_r.bank.lo <= rd_data_lo.data;
      end
      if (rden_m & dual_m) begin  // hi bank only read when unaligned
         rdata_r.bank.hi <= rd_data_hi.data;
      end
      if (|stbuf_fwd_m.byteen) begin
         fwd_data_r <= stbuf_fwd_m.data;
      end
   end

   assign corr_dw_r.bank.hi = ecc_r.sec_hi;
   assign corr_dw_r.bank.lo = ecc_r.sec_lo;

   assign ld_dw_r      = merge_bytes(rdata_r, fwd_data_r, fwd_byteen_r, in_dccm_r);
   assign ld_dw_corr_r = merge_bytes(corr_dw_r, fwd_data_r, fwd_byteen_r, in_dccm_r);

   assign ld_data_r      = align_word(ld_dw_r, lsu_addr_r[1:0]);
   assign ld_data_corr_r = align_word(ld_dw_corr_r, lsu_addr_r[1:0]);

   assign dma_rsp.rvalid    = lsu_pkt_r.valid & lsu_pkt_r.load & lsu_pkt_r.dma;
   assign dma_rsp.ecc_error = ecc_r.double_err;
   assign dma_rsp.rtag      = dma_tag_r;
   assign dma_rsp.rdata     = dual_r ? ld_dw_corr_r : {2{ld_dw_corr_r.bank.lo}};

endmodule

`default_nettype wire

/* hw/dccm_req_ctl.sv */
// Decode-stage request logic: access end address, unaligned flag, DCCM read
// port drive and the store-buffer grant for the write port.
`timescale 1ns/100ps
`default_nettype none

module dccm_req_ctl import lsu_dccm_pkg::*; #(
   parameter int DCCM_AW = 16
) (
   input  logic               clk,
   input  logic               arst_n,
   input  lsu_pkt_t           lsu_pkt_d,
   input  logic [DCCM_AW-1:0] lsu_addr_d,
   input  logic               addr_in_dccm_d,
   input  logic               dma_wen,       // dma write in D
   input  logic               stbuf_reqvld,  // entry waiting for the port
   input  logic [DCCM_AW-1:0] stbuf_addr,
   input  logic               ecc_wb_pend,   // correction write this cycle

   output logic               rden_d,
   output logic [DCCM_AW-1:0] end_addr_d,
   output logic               dual_d,
   output logic               stbuf_commit,
   output logic               dccm_rden,
   output logic [DCCM_AW-1:0] rd_addr_lo,
   output logic [DCCM_AW-1:0] rd_addr_hi
);

   logic [2:0] size_m1;     // bytes minus one
   logic       need_rd;     // access has to read the array
   logic       part_st;     // store that leaves old bytes in a word
   logic       port_idle;   // nothing in D uses the port
   logic       stbuf_hit;   // D read shares a bank row with stbuf

   assign size_m1 = ({3{lsu_pkt_d.half}}  & 3'd1) |
                    ({3{lsu_pkt_d.word}}  & 3'd3) |
                    ({3{lsu_pkt_d.dword}} & 3'd7);

   assign end_addr_d = lsu_addr_d + DCCM_AW'(size_m1);
   assign dual_d     = (lsu_addr_d[DCCM_AW-1:2] != end_addr_d[DCCM_AW-1:2]);

   // aligned word and dword stores rewrite the whole word with new ecc,
   // so only narrower or misaligned stores need the old contents
   assign part_st = lsu_pkt_d.store &
                    (~(lsu_pkt_d.word | lsu_pkt_d.dword) | (lsu_addr_d[1:0] != 2'b00));
   assign need_rd = lsu_pkt_d.load | part_st;
   assign rden_d  = lsu_pkt_d.valid & addr_in_dccm_d & need_rd;

   assign dccm_rden  = rden_d;
   assign rd_addr_lo = lsu_addr_d;   // start word
   assign rd_addr_hi = end_addr_d;   // next word when dual

   assign port_idle = ~(rden_d | dma_wen | ecc_wb_pend);
   assign stbuf_hit = (stbuf_addr[4:2] == lsu_addr_d[4:2]) |
                      (stbuf_addr[4:2] == end_addr_d[4:2]);

   assign stbuf_commit = stbuf_reqvld & (port_idle | (rden_d & ~stbuf_hit));

endmodule

`default_nettype wire

/* hw/lsu_dccm_pkg.sv */
// Widths and types shared by the DCCM control slice of the load/store unit.
// Imported by every RTL block of the slice and by its testbench.
`default_nettype none

package lsu_dccm_pkg;

   localparam int DCCM_DW    = 32;  // data bits per bank word
   localparam int DCCM_EW    = 7;   // ecc bits per bank word
   localparam int DCCM_BYTES = 8;   // bytes over both banks
   localparam int DMA_TAG_W  = 3;   // dma buffer entry number

   typedef struct packed {
      logic valid;
      logic load;
      logic store;
      logic dma;
      logic by;     // size flags, one-hot
      logic half;
      logic word;
      logic dword;
   } lsu_pkt_t;

   typedef struct packed {
      logic [DCCM_EW-1:0] ecc;
      logic [DCCM_DW-1:0] data;
   } dccm_word_t;

   typedef struct packed {
      logic [DCCM_DW-1:0] hi;
      logic [DCCM_DW-1:0] lo;
   } bank_pair_t;

   // one dword, seen per byte or per bank
   typedef union packed {
      logic [DCCM_BYTES-1:0][7:0] bytes;  // forwarding merge view
      bank_pair_t                 bank;   // capture and dma view
   } dword_u;

   typedef struct packed {
      dword_u                data;
      logic [DCCM_BYTES-1:0] byteen;  // bytes owned by the store buffer
   } stbuf_fwd_t;

   typedef struct packed {
      logic               wen;
      logic [DCCM_DW-1:0] wdata_lo;
      logic [DCCM_DW-1:0] wdata_hi;
      logic [DCCM_EW-1:0] ecc_lo;
      logic [DCCM_EW-1:0] ecc_hi;
   } dma_wr_t;

   typedef struct packed {
      logic                 rvalid;
      logic                 ecc_error;
      logic [DMA_TAG_W-1:0] rtag;
      dword_u               rdata;
   } dma_rsp_t;

   typedef struct packed {
      logic               single_lo;
      logic               single_hi;
      logic               double_err;
      logic [DCCM_DW-1:0] sec_lo;      // corrected lo bank word
      logic [DCCM_DW-1:0] sec_hi;      // corrected hi bank word
      logic [DCCM_EW-1:0] sec_ecc_lo;
      logic [DCCM_EW-1:0] sec_ecc_hi;
   } ecc_r_t;

endpackage

`default_nettype wire
